// File: common/student_config.svh
`ifndef STUDENT_CONFIG_SVH
`define STUDENT_CONFIG_SVH

// ======================================================================
// address map
// ======================================================================

// device select field of the byte address.
`define STUDENT_DEV_LSB  20
`define STUDENT_DEV_BITS 4

// running light registers.
`define RLIGHT_REG_CTRL    20'h0_0000
`define RLIGHT_REG_PATTERN 20'h0_0004
`define RLIGHT_REG_SPEED   20'h0_0008

// i2c controller registers.
`define IIC_REG_ADDR   20'h0_0000
`define IIC_REG_DATA   20'h0_0004
`define IIC_REG_CTRL   20'h0_0008
`define IIC_REG_STATUS 20'h0_000C

// clock cycles per scl half period.
`define IIC_CLK_DIV 4

`endif

// File: common/student_pkg.sv
`include "student_config.svh"

package student_pkg;

  // byte address, device field on top.
  typedef logic [23:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;

  // fields of the address.
  typedef logic [`STUDENT_DEV_BITS-1:0] dev_idx_t;
  typedef logic [`STUDENT_DEV_LSB-1:0]  reg_ofs_t;

  typedef logic [7:0] led_t;

  // ====================================================================
  // bus structs
  // ====================================================================

  typedef struct packed {
    logic      valid;
    logic      we;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic      valid;
    logic      err;   // unmapped device.
    bus_data_t rdata;
  } bus_rsp_t;

  // ====================================================================
  // i2c controller
  // ====================================================================

  typedef enum logic [2:0] {
    IIC_IDLE,
    IIC_START,
    IIC_SHIFT, // address or data bit.
    IIC_ACK,
    IIC_STOP
  } iic_state_t;

endpackage

// File: logic/student_bus_mux.sv
`timescale 1ns/1ps
`include "student_config.svh"

module student_bus_mux #(
  parameter int unsigned NUM_DEV = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  student_pkg::bus_req_t host_req_i,
  output student_pkg::bus_rsp_t host_rsp_o,
  output student_pkg::bus_req_t dev_req_o [NUM_DEV-1:0],
  input  student_pkg::bus_rsp_t dev_rsp_i [NUM_DEV-1:0]
);
  import student_pkg::*;

  dev_idx_t dev_idx;
  logic     mapped;
  logic     err_q;

  assign dev_idx = host_req_i.addr[`STUDENT_DEV_LSB +: `STUDENT_DEV_BITS];
  assign mapped  = (dev_idx < dev_idx_t'(NUM_DEV));

  // valid only toward the selected device.
  always_comb begin
    for (int i = 0; i < NUM_DEV; i++) begin
      dev_req_o[i]       = host_req_i;
      dev_req_o[i].valid = host_req_i.valid && (dev_idx == dev_idx_t'(i));
    end
  end

  // unmapped index answers itself, one cycle later.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= host_req_i.valid && !mapped;
    end
  end

  // ====================================================================
  // response merge
  // ====================================================================

  // at most one source is valid per cycle.
  always_comb begin
    host_rsp_o = '0;
    if (err_q) begin
      host_rsp_o.valid = 1'b1;
      host_rsp_o.err   = 1'b1;
    end
    for (int i = 0; i < NUM_DEV; i++) begin
      if (dev_rsp_i[i].valid) begin
        host_rsp_o = dev_rsp_i[i];
      end
    end
  end

endmodule

// File: rlight/student_rlight.sv
`timescale 1ns/1ps
`include "student_config.svh"

module student_rlight (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  student_pkg::bus_req_t bus_req_i,
  output student_pkg::bus_rsp_t bus_rsp_o,
  output student_pkg::led_t     led_o
);
  import student_pkg::*;

  typedef logic [15:0] speed_t;

  logic [1:0] ctrl_q;    // bit 0 enable, bit 1 right.
  led_t       pattern_q;
  speed_t     speed_q;
  speed_t     cnt_q;
  logic       tick;
  logic       wr_en;
  reg_ofs_t   reg_ofs;
  bus_data_t  rdata;
  bus_data_t  rdata_q;
  logic       rsp_valid_q;

  assign reg_ofs = bus_req_i.addr[`STUDENT_DEV_LSB-1:0];
  assign wr_en   = bus_req_i.valid && bus_req_i.we;
  assign tick    = (cnt_q == '0);

  // ====================================================================
  // registers and rotator
  // ====================================================================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_q    <= '0;
      pattern_q <= '0;
      speed_q   <= '0;
      cnt_q     <= '0;
    end else begin
      if (tick) begin
        cnt_q <= speed_q; // period is speed + 1.
      end else begin
        cnt_q <= cnt_q - 16'd1;
      end

      if (tick && ctrl_q[0]) begin
        if (ctrl_q[1]) begin
          pattern_q <= {pattern_q[0], pattern_q[7:1]};
        end else begin
          pattern_q <= {pattern_q[6:0], pattern_q[7]};
        end
      end

      // bus writes override the rotator.
      if (wr_en) begin
        case (reg_ofs)
          `RLIGHT_REG_CTRL:    ctrl_q  <= bus_req_i.wdata[1:0];
          `RLIGHT_REG_SPEED:   speed_q <= bus_req_i.wdata[15:0];
          `RLIGHT_REG_PATTERN: begin
            pattern_q <= bus_req_i.wdata[7:0];
            cnt_q     <= speed_q; // restart the period.
          end
          default: ;
        endcase
      end
    end
  end

  assign led_o = pattern_q;

  // ====================================================================
  // read path
  // ====================================================================

  always_comb begin
    rdata = '0;
    case (reg_ofs)
      `RLIGHT_REG_CTRL:    rdata = {30'b0, ctrl_q};
      `RLIGHT_REG_PATTERN: rdata = {24'b0, pattern_q};
      `RLIGHT_REG_SPEED:   rdata = {16'b0, speed_q};
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= bus_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= (bus_req_i.valid && !bus_req_i.we) ? rdata : '0; // writes return zero.
  end

  assign bus_rsp_o = '{valid: rsp_valid_q, err: 1'b0, rdata: rdata_q};

endmodule

// File: iic/student_iic_ctrl.sv
`timescale 1ns/1ps
`include "student_config.svh"

module student_iic_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  student_pkg::bus_req_t bus_req_i,
  output student_pkg::bus_rsp_t bus_rsp_o,
  input  logic                  sda_i,
  input  logic                  scl_i,
  output logic                  sda_oe_o,
  output logic                  scl_oe_o
);
  import student_pkg::*;

  localparam int unsigned DIV = `IIC_CLK_DIV;
  localparam int unsigned MID = DIV / 2;

  typedef logic [7:0] div_cnt_t;
  typedef logic [7:0] iic_byte_t;

  iic_state_t state_q;
  div_cnt_t   div_q;
  logic       phase_q;    // 0 scl low half, 1 scl high half.
  logic [2:0] bit_cnt_q;
  logic       byte_sel_q; // 0 address byte, 1 data byte.
  iic_byte_t  shift_q;
  iic_byte_t  addr_q;
  iic_byte_t  data_q;
  logic       addr_nack_q;
  logic       data_nack_q;
  logic       sda_oe_q;
  logic       scl_oe_q;
  logic       busy;
  logic       wr_en;
  logic       start_cmd;
  logic       half_tick;
  logic       mid_tick;
  logic       bit_end;
  logic       nack;
  reg_ofs_t   reg_ofs;
  bus_data_t  rdata;
  bus_data_t  rdata_q;
  logic       rsp_valid_q;

  assign reg_ofs   = bus_req_i.addr[`STUDENT_DEV_LSB-1:0];
  assign wr_en     = bus_req_i.valid && bus_req_i.we;
  assign busy      = (state_q != IIC_IDLE);
  assign start_cmd = wr_en && (reg_ofs == `IIC_REG_CTRL) && bus_req_i.wdata[0] && !busy;
  assign half_tick = busy && (div_q == div_cnt_t'(DIV - 1));
  assign mid_tick  = busy && (div_q == div_cnt_t'(MID));
  assign bit_end   = half_tick && phase_q;
  assign nack      = sda_i || !scl_i; // ack needs scl really high.

  // ====================================================================
  // bit timer and FSM
  // ====================================================================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IIC_IDLE;
      div_q       <= '0;
      phase_q     <= 1'b0;
      scl_oe_q    <= 1'b0;
      sda_oe_q    <= 1'b0;
      addr_nack_q <= 1'b0;
      data_nack_q <= 1'b0;
    end else if (start_cmd) begin
      state_q     <= IIC_START;
      div_q       <= '0;
      phase_q     <= 1'b0;
      addr_nack_q <= 1'b0;
      data_nack_q <= 1'b0;
    end else if (busy) begin
      div_q <= half_tick ? '0 : div_q + 8'd1;
      if (half_tick) begin
        phase_q  <= ~phase_q;
        scl_oe_q <= phase_q && (state_q != IIC_STOP); // low half of next bit.
      end

      // sda moves mid low half, start/stop and ack mid high half.
      if (mid_tick && !phase_q) begin
        case (state_q)
          IIC_SHIFT: sda_oe_q <= ~shift_q[7];
          IIC_ACK:   sda_oe_q <= 1'b0;
          IIC_STOP:  sda_oe_q <= 1'b1;
          default: ;
        endcase
      end
      if (mid_tick && phase_q) begin
        case (state_q)
          IIC_START: sda_oe_q <= 1'b1;
          IIC_STOP:  sda_oe_q <= 1'b0;
          IIC_ACK: begin
            if (byte_sel_q) begin
              data_nack_q <= nack;
            end else begin
              addr_nack_q <= nack;
            end
          end
          default: ;
        endcase
      end

      if (bit_end) begin
        case (state_q)
          IIC_START: state_q <= IIC_SHIFT;
          IIC_SHIFT: begin
            if (bit_cnt_q == 3'd7) begin
              state_q <= IIC_ACK;
            end
          end
          IIC_ACK:   state_q <= byte_sel_q ? IIC_STOP : IIC_SHIFT;
          IIC_STOP:  state_q <= IIC_IDLE;
          default:   state_q <= IIC_IDLE;
        endcase
      end
    end
  end

  // shifter, msb first.
  always_ff @(posedge clk_i) begin
    if (bit_end) begin
      case (state_q)
        IIC_START: begin
          shift_q    <= addr_q;
          bit_cnt_q  <= '0;
          byte_sel_q <= 1'b0;
        end
        IIC_SHIFT: begin
          shift_q   <= {shift_q[6:0], 1'b0};
          bit_cnt_q <= bit_cnt_q + 3'd1;
        end
        IIC_ACK: begin
          shift_q    <= data_q;
          bit_cnt_q  <= '0;
          byte_sel_q <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign sda_oe_o = sda_oe_q;
  assign scl_oe_o = scl_oe_q;

  // ====================================================================
  // bus registers
  // ====================================================================

  always_ff @(posedge clk_i) begin
    if (wr_en && (reg_ofs == `IIC_REG_ADDR)) begin
      addr_q <= bus_req_i.wdata[7:0]; // 7-bit target plus r/w.
    end
    if (wr_en && (reg_ofs == `IIC_REG_DATA)) begin
      data_q <= bus_req_i.wdata[7:0];
    end
  end

  always_comb begin
    rdata = '0;
    case (reg_ofs)
      `IIC_REG_ADDR:   rdata = {24'b0, addr_q};
      `IIC_REG_DATA:   rdata = {24'b0, data_q};
      `IIC_REG_STATUS: rdata = {29'b0, data_nack_q, addr_nack_q, busy};
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= bus_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= (bus_req_i.valid && !bus_req_i.we) ? rdata : '0;
  end

  assign bus_rsp_o = '{valid: rsp_valid_q, err: 1'b0, rdata: rdata_q};

endmodule

// File: logic/student_top.sv
`timescale 1ns/1ps

module student_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  student_pkg::bus_req_t bus_req_i,
  output student_pkg::bus_rsp_t bus_rsp_o,
  output student_pkg::led_t     led_o,
  input  logic                  sda_i,
  input  logic                  scl_i,
  output logic                  sda_oe_o,
  output logic                  scl_oe_o
);
  import student_pkg::*;

  localparam int unsigned NUM_DEV = 2;

  // device 0 running light, device 1 i2c.
  bus_req_t dev_req [NUM_DEV-1:0];
  bus_rsp_t dev_rsp [NUM_DEV-1:0];

  student_bus_mux #(
    .NUM_DEV(NUM_DEV)
  ) bus_mux_i (
    .clk_i,
    .rst_i,
    .host_req_i(bus_req_i),
    .host_rsp_o(bus_rsp_o),
    .dev_req_o (dev_req),
    .dev_rsp_i (dev_rsp)
  );

  student_rlight rlight_i (
    .clk_i,
    .rst_i,
    .bus_req_i(dev_req[0]),
    .bus_rsp_o(dev_rsp[0]),
    .led_o
  );

  student_iic_ctrl iic_ctrl_i (
    .clk_i,
    .rst_i,
    .bus_req_i(dev_req[1]),
    .bus_rsp_o(dev_rsp[1]),
    .sda_i,
    .scl_i,
    .sda_oe_o,
    .scl_oe_o
  );

endmodule

// File: verification/student_tb.sv
`timescale 1ns/1ps
`include "student_config.svh"

module student_tb;
  import student_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int NUM_TESTS   = 19;
  localparam int XFER_CYCLES = 40 * `IIC_CLK_DIV;  // one i2c write.
  localparam int POLL_LIMIT  = 2 * XFER_CYCLES;
  localparam int LED_SPEED   = 3;
  localparam int LED_STEPS   = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 2 + 3 * XFER_CYCLES + 3000;
  localparam logic [6:0] TARGET_ADDR = 7'h3C;

  typedef struct {
    string     name;
    logic      we;
    bus_addr_t addr;
    bus_data_t wdata;
    bus_data_t exp_rdata;
    logic      exp_err;
  } bus_test_t;

  logic      clk;
  logic      rst;
  bus_req_t  bus_req;
  bus_rsp_t  bus_rsp;
  led_t      led;
  logic      sda_in = 1'b1;
  logic      scl_in = 1'b1;
  logic      sda_oe;
  logic      scl_oe;
  logic      sda_line;
  logic      scl_line;

  bus_test_t   tests [NUM_TESTS];
  int          n_tests   = 0;
  int          tests_run = 0;
  int          errors    = 0;
  logic [15:0] lfsr_q    = 16'd24;

  // i2c target model state.
  logic       sda_p;
  logic       scl_p;
  logic       tgt_pull;
  logic       tgt_active;
  logic       tgt_hit;
  logic [7:0] tgt_shift;
  logic [7:0] tgt_byte0;
  logic [7:0] tgt_byte1;
  int         tgt_bit_cnt;
  int         tgt_byte_idx;
  int         starts;
  int         stops;
  int         bytes_at_stop;

  student_top uut (
    .clk_i   (clk),
    .rst_i   (rst),
    .bus_req_i(bus_req),
    .bus_rsp_o(bus_rsp),
    .led_o   (led),
    .sda_i   (sda_in),
    .scl_i   (scl_in),
    .sda_oe_o(sda_oe),
    .scl_oe_o(scl_oe)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  // ======================================================================
  // open-drain lines and i2c target
  // ======================================================================

  assign sda_line = !(sda_oe || tgt_pull);
  assign scl_line = !scl_oe;

  always @(posedge clk) begin
    sda_in <= sda_line;
    scl_in <= scl_line;
  end

  always @(negedge clk) begin
    if (rst) begin
      sda_p         <= 1'b1;
      scl_p         <= 1'b1;
      tgt_pull      <= 1'b0;
      tgt_active    <= 1'b0;
      tgt_hit       <= 1'b0;
      tgt_shift     <= '0;
      tgt_byte0     <= '0;
      tgt_byte1     <= '0;
      tgt_bit_cnt   <= 0;
      tgt_byte_idx  <= 0;
      starts        <= 0;
      stops         <= 0;
      bytes_at_stop <= 0;
    end else begin
      sda_p <= sda_line;
      scl_p <= scl_line;
      if (scl_line && scl_p && sda_p && !sda_line) begin  // start.
        tgt_active   <= 1'b1;
        tgt_hit      <= 1'b0;
        tgt_bit_cnt  <= 0;
        tgt_byte_idx <= 0;
        starts       <= starts + 1;
      end else if (scl_line && scl_p && !sda_p && sda_line) begin  // stop.
        tgt_active    <= 1'b0;
        tgt_pull      <= 1'b0;
        stops         <= stops + 1;
        bytes_at_stop <= tgt_byte_idx;
      end else if (tgt_active && !scl_p && scl_line) begin
        if (tgt_bit_cnt < 8) begin
          tgt_shift <= {tgt_shift[6:0], sda_line};  // msb first.
        end
        tgt_bit_cnt <= tgt_bit_cnt + 1;
      end else if (tgt_active && scl_p && !scl_line) begin
        if (tgt_bit_cnt == 8) begin
          if (tgt_byte_idx == 0) begin
            tgt_byte0 <= tgt_shift;
            tgt_hit   <= (tgt_shift[7:1] == TARGET_ADDR);
            tgt_pull  <= (tgt_shift[7:1] == TARGET_ADDR);
          end else begin
            tgt_byte1 <= tgt_shift;
            tgt_pull  <= tgt_hit;  // data acked only when addressed.
          end
        end else if (tgt_bit_cnt == 9) begin
          tgt_pull     <= 1'b0;
          tgt_bit_cnt  <= 0;
          tgt_byte_idx <= tgt_byte_idx + 1;
        end
      end
    end
  end

  // ======================================================================
  // helpers
  // ======================================================================

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic bus_data_t random_bits(input int n);
    bus_data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic bus_addr_t dev_addr(input int dev, input reg_ofs_t ofs);
    bus_addr_t a;
    a = '0;
    a[`STUDENT_DEV_LSB +: `STUDENT_DEV_BITS] = dev_idx_t'(dev);
    a[`STUDENT_DEV_LSB-1:0] = ofs;
    return a;
  endfunction

  function automatic led_t rotl(input led_t p);
    return {p[6:0], p[7]};
  endfunction

  function automatic led_t rotr(input led_t p);
    return {p[0], p[7:1]};
  endfunction

  function automatic void add_test(input string name, input logic we, input bus_addr_t addr,
                                   input bus_data_t wdata, input bus_data_t exp_rdata,
                                   input logic exp_err);
    tests[n_tests].name      = name;
    tests[n_tests].we        = we;
    tests[n_tests].addr      = addr;
    tests[n_tests].wdata     = wdata;
    tests[n_tests].exp_rdata = exp_rdata;
    tests[n_tests].exp_err   = exp_err;
    n_tests++;
  endfunction

  function automatic void fill_table();
    bus_data_t r0;
    bus_data_t r1;
    bus_data_t r2;
    bus_data_t r3;
    r0 = random_bits(32);
    r1 = random_bits(32);
    r2 = random_bits(32);
    r3 = random_bits(32);
    add_test("rst pattern", 1'b0, dev_addr(0, `RLIGHT_REG_PATTERN), '0, '0, 1'b0);
    add_test("rst speed", 1'b0, dev_addr(0, `RLIGHT_REG_SPEED), '0, '0, 1'b0);
    add_test("rst status", 1'b0, dev_addr(1, `IIC_REG_STATUS), '0, '0, 1'b0);
    add_test("wr pattern", 1'b1, dev_addr(0, `RLIGHT_REG_PATTERN), r0, '0, 1'b0);
    add_test("rd pattern", 1'b0, dev_addr(0, `RLIGHT_REG_PATTERN), '0, r0 & 32'hFF, 1'b0);
    add_test("wr speed", 1'b1, dev_addr(0, `RLIGHT_REG_SPEED), r1, '0, 1'b0);
    add_test("rd speed", 1'b0, dev_addr(0, `RLIGHT_REG_SPEED), '0, r1 & 32'hFFFF, 1'b0);
    add_test("wr iic addr", 1'b1, dev_addr(1, `IIC_REG_ADDR), r2, '0, 1'b0);
    add_test("rd iic addr", 1'b0, dev_addr(1, `IIC_REG_ADDR), '0, r2 & 32'hFF, 1'b0);
    add_test("wr iic data", 1'b1, dev_addr(1, `IIC_REG_DATA), r3, '0, 1'b0);
    add_test("rd iic data", 1'b0, dev_addr(1, `IIC_REG_DATA), '0, r3 & 32'hFF, 1'b0);
    // unmapped devices alias the real register offsets.
    add_test("wr dev2 pattern", 1'b1, dev_addr(2, `RLIGHT_REG_PATTERN), ~r0, '0, 1'b1);
    add_test("wr dev3 addr", 1'b1, dev_addr(3, `IIC_REG_ADDR), ~r2, '0, 1'b1);
    add_test("wr dev15 speed", 1'b1, dev_addr(15, `RLIGHT_REG_SPEED), ~r1, '0, 1'b1);
    add_test("rd dev9", 1'b0, dev_addr(9, `RLIGHT_REG_PATTERN), '0, '0, 1'b1);
    add_test("pattern kept", 1'b0, dev_addr(0, `RLIGHT_REG_PATTERN), '0, r0 & 32'hFF, 1'b0);
    add_test("speed kept", 1'b0, dev_addr(0, `RLIGHT_REG_SPEED), '0, r1 & 32'hFFFF, 1'b0);
    add_test("iic addr kept", 1'b0, dev_addr(1, `IIC_REG_ADDR), '0, r2 & 32'hFF, 1'b0);
    add_test("rd unknown ofs", 1'b0, dev_addr(0, 20'h0_0010), '0, '0, 1'b0);
  endfunction

  // ======================================================================
  // compare tasks
  // ======================================================================

  task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
    tests_run++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end else begin
      $display("ok   %s: %h", name, act);
    end
  endtask

  task automatic check_led(input string name, input led_t exp, input led_t act);
    tests_run++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end else begin
      $display("ok   %s: %h", name, act);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    tests_run++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s err: expected %b, actual %b", name, exp, act);
    end else begin
      $display("ok   %s err: %b", name, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    tests_run++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end else begin
      $display("ok   %s: %b", name, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    tests_run++;
    if (act != exp) begin
      errors++;
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
    end else begin
      $display("ok   %s: %0d", name, act);
    end
  endtask

  // ======================================================================
  // bus and device sequences
  // ======================================================================

  // one request, response sampled one cycle later.
  task automatic bus_xfer(input string name, input logic we, input bus_addr_t addr,
                          input bus_data_t wdata, output bus_rsp_t rsp);
    @(posedge clk);
    bus_req <= '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
    @(negedge clk);
    if (bus_rsp.valid) begin
      errors++;
      $display("Error: %s got a response before its request was accepted", name);
    end
    @(posedge clk);
    bus_req <= '0;
    @(negedge clk);
    rsp = bus_rsp;
    if (!rsp.valid) begin
      errors++;
      $display("Error: %s got no response one cycle after its request", name);
    end
  endtask

  task automatic wait_led_change(input led_t prev, output int cycles, output logic changed);
    cycles  = 0;
    changed = 1'b0;
    while (!changed && cycles < 4 * (LED_SPEED + 1)) begin
      @(negedge clk);
      cycles++;
      changed = (led !== prev);
    end
    if (!changed) begin
      errors++;
      $display("Error: led_o did not change within %0d cycles", cycles);
    end
  endtask

  task automatic step_led(input string name, input logic right);
    led_t prev;
    led_t exp;
    int   cycles;
    logic changed;
    prev = led;
    for (int i = 0; i < LED_STEPS; i++) begin
      wait_led_change(prev, cycles, changed);
      if (!changed) break;
      exp = right ? rotr(prev) : rotl(prev);
      check_led($sformatf("%s step %0d", name, i), exp, led);
      if (i > 0) begin  // first change depends on the counter phase.
        check_count($sformatf("%s hold %0d", name, i), LED_SPEED + 1, cycles);
      end
      prev = led;
    end
  endtask

  task automatic run_iic(input string name, input logic [7:0] addr_byte,
                         input logic [7:0] data_byte, input logic retrigger);
    int        starts_before;
    int        stops_before;
    int        polls;
    int        busy_cycles;
    time       t_start;
    logic      hit;
    bus_rsp_t  rsp;
    bus_data_t exp_status;
    starts_before = starts;
    stops_before  = stops;
    hit = (addr_byte[7:1] == TARGET_ADDR);
    exp_status = {29'b0, !hit, !hit, 1'b0};
    bus_xfer({name, " addr"}, 1'b1, dev_addr(1, `IIC_REG_ADDR), {24'b0, addr_byte}, rsp);
    bus_xfer({name, " data"}, 1'b1, dev_addr(1, `IIC_REG_DATA), {24'b0, data_byte}, rsp);
    bus_xfer({name, " start"}, 1'b1, dev_addr(1, `IIC_REG_CTRL), 32'h1, rsp);
    t_start = $time;
    bus_xfer({name, " status"}, 1'b0, dev_addr(1, `IIC_REG_STATUS), '0, rsp);
    check_bit({name, " busy"}, 1'b1, rsp.rdata[0]);
    if (retrigger) begin
      repeat (XFER_CYCLES / 2) @(negedge clk); // halfway through the transfer.
      bus_xfer({name, " restart"}, 1'b1, dev_addr(1, `IIC_REG_CTRL), 32'h1, rsp);
    end
    polls = 0;
    bus_xfer({name, " poll"}, 1'b0, dev_addr(1, `IIC_REG_STATUS), '0, rsp);
    while (rsp.rdata[0] === 1'b1 && polls < POLL_LIMIT) begin
      bus_xfer({name, " poll"}, 1'b0, dev_addr(1, `IIC_REG_STATUS), '0, rsp);
      polls++;
    end
    if (rsp.rdata[0] !== 1'b0) begin
      errors++;
      $display("Error: %s busy did not fall after %0d status reads", name, polls);
    end
    busy_cycles = int'(($time - t_start) / CLK_PERIOD);
    tests_run++;
    if (busy_cycles < XFER_CYCLES || busy_cycles > XFER_CYCLES + 4) begin
      errors++;
      $display("Error: %s stayed busy for %0d cycles, one transfer takes %0d",
               name, busy_cycles, XFER_CYCLES);
    end else begin
      $display("ok   %s busy cycles: %0d", name, busy_cycles);
    end
    check_data({name, " done status"}, exp_status, rsp.rdata);
    if (retrigger) begin
      repeat (XFER_CYCLES) @(negedge clk);
      bus_xfer({name, " idle"}, 1'b0, dev_addr(1, `IIC_REG_STATUS), '0, rsp);
      check_bit({name, " still idle"}, 1'b0, rsp.rdata[0]);
    end
    check_count({name, " starts"}, starts_before + 1, starts);
    check_count({name, " stops"}, stops_before + 1, stops);
    check_count({name, " bytes"}, 2, bytes_at_stop);
    check_data({name, " addr byte"}, {24'b0, addr_byte}, {24'b0, tgt_byte0});
    check_data({name, " data byte"}, {24'b0, data_byte}, {24'b0, tgt_byte1});
  endtask

  // ======================================================================
  // main sequence
  // ======================================================================

  initial begin
    bus_rsp_t  rsp;
    bus_data_t tmp;
    led_t      pat;
    rst     <= 1'b1;
    bus_req <= '0;
    fill_table();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    check_bit("rst rsp valid", 1'b0, bus_rsp.valid);
    check_bit("rst sda_oe", 1'b0, sda_oe);
    check_bit("rst scl_oe", 1'b0, scl_oe);
    check_led("rst led", 8'h00, led);

    for (int i = 0; i < NUM_TESTS; i++) begin
      bus_xfer(tests[i].name, tests[i].we, tests[i].addr, tests[i].wdata, rsp);
      check_err(tests[i].name, tests[i].exp_err, rsp.err);
      check_data(tests[i].name, tests[i].exp_rdata, rsp.rdata);
    end

    // running light.
    tmp = random_bits(8);
    pat = tmp[7:0];
    if (rotl(pat) == rotr(pat)) begin
      pat = 8'h35; // direction would not show.
    end
    bus_xfer("led speed", 1'b1, dev_addr(0, `RLIGHT_REG_SPEED), bus_data_t'(LED_SPEED), rsp);
    bus_xfer("led pattern", 1'b1, dev_addr(0, `RLIGHT_REG_PATTERN), {24'b0, pat}, rsp);
    check_led("led pattern load", pat, led);
    bus_xfer("led ctrl left", 1'b1, dev_addr(0, `RLIGHT_REG_CTRL), 32'h1, rsp);
    step_led("led left", 1'b0);
    bus_xfer("led ctrl right", 1'b1, dev_addr(0, `RLIGHT_REG_CTRL), 32'h3, rsp);
    step_led("led right", 1'b1);

    // i2c writes.
    tmp = random_bits(8);
    run_iic("iic match", {TARGET_ADDR, 1'b0}, tmp[7:0], 1'b0);
    tmp = random_bits(8);
    run_iic("iic no match", {TARGET_ADDR ^ 7'h11, 1'b0}, tmp[7:0], 1'b1);

    $display("tests: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+common
common/student_pkg.sv
logic/student_bus_mux.sv
rlight/student_rlight.sv
iic/student_iic_ctrl.sv
logic/student_top.sv
verification/student_tb.sv

// File: Makefile
SIM := obj_dir/student_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -f files.f --top-module student_tb -Mdir obj_dir -o student_sim

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
